// ==== include/bb_config.svh ====
`ifndef BB_CONFIG_SVH
`define BB_CONFIG_SVH

// timing, clk_6M based
`define BB_CYCLES_PER_US        6
`define BB_CYCLES_PER_HALF_SLOT 1875
`define BB_CLKN_W               28

// access code widths
`define BB_LAP_W                24
`define BB_SW_W                 64
`define BB_INFO_W               30
`define BB_PAR_W                34
`define BB_THR_W                6

// BCH(64,30) generator, bit index equals the power of D
`define BB_BCH_POLY             35'o260534236651

// scrambling sequence, bit 63 pairs with info bit 29
`define BB_PN                   64'h83848D96BBCC54FC

// appends chosen by lap bit 23
`define BB_BARKER_0             6'b001101
`define BB_BARKER_1             6'b110010

// register map
`define BB_REG_ADDR_W           2
`define BB_REG_CTRL             2'd0
`define BB_REG_LAP              2'd1
`define BB_REG_THRESH           2'd2
`define BB_REG_CALC             2'd3

`endif

// ==== source/bb_pkg.sv ====
`default_nettype none

`include "bb_config.svh"

package bb_pkg;

  typedef enum logic [`BB_REG_ADDR_W-1:0] {
    REG_CTRL   = `BB_REG_CTRL,
    REG_LAP    = `BB_REG_LAP,
    REG_THRESH = `BB_REG_THRESH,
    REG_CALC   = `BB_REG_CALC
  } reg_addr_e;

  // 31 bits
  typedef struct packed {
    logic                 corr_en;
    logic [`BB_LAP_W-1:0] lap;
    logic [`BB_THR_W-1:0] thresh;
  } bb_cfg_t;

  typedef logic [`BB_SW_W-1:0] syncword_t;

  typedef struct packed {
    logic p_1us;
    logic half_slot_p;
    logic slot_p;
  } bb_tick_t;

  typedef enum logic [1:0] {
    SW_IDLE,
    SW_SHIFT,
    SW_DONE
  } sw_state_e;

endpackage

`default_nettype wire

// ==== source/bb_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bb_config.svh"

module bb_cfg_regs
(
  input  wire                     clk_6M,
  input  wire                     rstz,
  input  wire                     reg_we,
  input  wire bb_pkg::reg_addr_e  reg_addr,
  input  wire logic [31:0]        reg_wdata,
  output bb_pkg::bb_cfg_t         cfg,
  output logic                    calc_p
);

  import bb_pkg::*;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      cfg <= '0;
    end
    else if (reg_we)
    begin
      case (reg_addr)
        REG_CTRL:
        begin
          cfg.corr_en <= reg_wdata[0];
        end
        REG_LAP:
        begin
          cfg.lap <= reg_wdata[`BB_LAP_W-1:0];
        end
        REG_THRESH:
        begin
          cfg.thresh <= reg_wdata[`BB_THR_W-1:0];
        end
        default:
        begin
          cfg <= cfg;
        end
      endcase
    end
  end

  // start strobe for the sync word generator, data ignored
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      calc_p <= 1'b0;
    end
    else
    begin
      calc_p <= reg_we && (reg_addr == REG_CALC);
    end
  end

endmodule

`default_nettype wire

// ==== source/bb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bb_config.svh"

module bb_clkgen
(
  input  wire                           clk_6M,
  input  wire                           rstz,
  output bb_pkg::bb_tick_t              tick,
  output logic [`BB_CLKN_W-1:0]         clkn
);

  localparam int US_W = $clog2(`BB_CYCLES_PER_US);
  localparam int HS_W = $clog2(`BB_CYCLES_PER_HALF_SLOT);
  localparam logic [US_W-1:0] US_LAST = US_W'(`BB_CYCLES_PER_US - 1);
  localparam logic [HS_W-1:0] HS_LAST = HS_W'(`BB_CYCLES_PER_HALF_SLOT - 1);

  logic [US_W-1:0] us_cnt;
  logic [HS_W-1:0] hs_cnt;
  logic            p_1us_q;
  logic            half_slot_q;
  logic            slot_q;

  // divide by 6 for the microsecond tick
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      us_cnt  <= '0;
      p_1us_q <= 1'b0;
    end
    else
    begin
      us_cnt  <= (us_cnt == US_LAST) ? '0 : us_cnt + 1'b1;
      p_1us_q <= (us_cnt == US_LAST);
    end
  end

  // 312.5 us half slot
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      hs_cnt      <= '0;
      half_slot_q <= 1'b0;
    end
    else
    begin
      hs_cnt      <= (hs_cnt == HS_LAST) ? '0 : hs_cnt + 1'b1;
      half_slot_q <= (hs_cnt == HS_LAST);
    end
  end

  // native clock, slot pulse lines up with bit 0 falling
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      clkn   <= '0;
      slot_q <= 1'b0;
    end
    else
    begin
      if (half_slot_q)
        clkn <= clkn + 1'b1;
      slot_q <= half_slot_q && clkn[0];
    end
  end

  assign tick.p_1us       = p_1us_q;
  assign tick.half_slot_p = half_slot_q;
  assign tick.slot_p      = slot_q;

endmodule

`default_nettype wire

// ==== source/bb_syncword_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bb_config.svh"

module bb_syncword_gen
(
  input  wire                       clk_6M,
  input  wire                       rstz,
  input  wire                       calc_p,
  input  wire bb_pkg::bb_cfg_t      cfg,
  output bb_pkg::syncword_t         syncword,
  output logic                      sw_ready
);

  import bb_pkg::*;

  localparam int INFO_MSB = `BB_INFO_W - 1;
  localparam int CNT_W    = $clog2(`BB_INFO_W);
  localparam logic [`BB_PAR_W:0]   GEN_FULL = `BB_BCH_POLY;
  localparam logic [`BB_PAR_W-1:0] GEN_LOW  = GEN_FULL[`BB_PAR_W-1:0];
  localparam logic [`BB_SW_W-1:0]  PN       = `BB_PN;

  sw_state_e             state;
  logic [CNT_W-1:0]      bit_cnt;
  logic                  last_bit;
  logic [`BB_INFO_W-1:0] info_q;
  logic [`BB_INFO_W-1:0] info_nxt;
  logic [`BB_PAR_W-1:0]  rem_q;
  logic [`BB_PAR_W-1:0]  rem_nxt;
  logic                  fb;

  always_comb
  begin
    // barker append picked by the lap msb, then scrambled by upper PN
    info_nxt = {(cfg.lap[`BB_LAP_W-1] ? `BB_BARKER_1 : `BB_BARKER_0), cfg.lap}
               ^ PN[`BB_SW_W-1 -: `BB_INFO_W];
    // one division step, msb first
    fb      = info_q[INFO_MSB - int'(bit_cnt)] ^ rem_q[`BB_PAR_W-1];
    rem_nxt = {rem_q[`BB_PAR_W-2:0], 1'b0} ^ (fb ? GEN_LOW : '0);
  end

  assign last_bit = (bit_cnt == CNT_W'(INFO_MSB));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state    <= SW_IDLE;
      bit_cnt  <= '0;
      syncword <= '0;
      sw_ready <= 1'b0;
    end
    else
    begin
      sw_ready <= 1'b0;
      case (state)
        SW_IDLE:
        begin
          if (calc_p)
          begin
            state   <= SW_SHIFT;
            bit_cnt <= '0;
          end
        end
        SW_SHIFT:
        begin
          bit_cnt <= bit_cnt + 1'b1;
          if (last_bit)
          begin
            // result lands on the edge into SW_DONE
            syncword <= {info_q, rem_nxt} ^ PN;
            sw_ready <= 1'b1;
            state    <= SW_DONE;
          end
        end
        SW_DONE:
        begin
          state <= SW_IDLE;
        end
        default:
        begin
          state <= SW_IDLE;
        end
      endcase
    end
  end

  // info word and running remainder
  always_ff @(posedge clk_6M)
  begin
    if ((state == SW_IDLE) && calc_p)
    begin
      info_q <= info_nxt;
      rem_q  <= '0;
    end
    else if (state == SW_SHIFT)
    begin
      rem_q <= rem_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== source/bb_rx_correlator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bb_config.svh"

module bb_rx_correlator
(
  input  wire                         clk_6M,
  input  wire                         rstz,
  input  wire                         rxbit,
  input  wire bb_pkg::bb_tick_t       tick,
  input  wire bb_pkg::bb_cfg_t        cfg,
  input  wire bb_pkg::syncword_t      syncword,
  input  wire                         sw_ready,
  output logic                        sync_hit
);

  localparam int CNT_W = $clog2(`BB_SW_W + 1);

  logic [1:0]          rx_meta;
  logic [`BB_SW_W-1:0] sync_in;
  logic [`BB_SW_W-1:0] sync_in_nxt;
  logic                sw_valid;
  logic [CNT_W-1:0]    mism_cnt;
  logic                thr_ok;

  // two flop resync of the async rx line
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rx_meta <= 2'b00;
    else
      rx_meta <= {rx_meta[0], rxbit};
  end

  // newest bit at the top, lsb first on air
  assign sync_in_nxt = {rx_meta[1], sync_in[`BB_SW_W-1:1]};

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      sync_in <= '0;
    else if (tick.p_1us)
      sync_in <= sync_in_nxt;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      sw_valid <= 1'b0;
    else if (sw_ready)
      sw_valid <= 1'b1;
  end

  // mismatch count against the word that is about to be sampled
  always_comb
  begin
    mism_cnt = '0;
    for (int i = 0; i < `BB_SW_W; i++)
    begin
      mism_cnt = mism_cnt + CNT_W'(sync_in_nxt[i] ^ syncword[i]);
    end
  end

  assign thr_ok = (mism_cnt <= CNT_W'(cfg.thresh));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      sync_hit <= 1'b0;
    else
      sync_hit <= tick.p_1us && cfg.corr_en && sw_valid && thr_ok;
  end

endmodule

`default_nettype wire

// ==== source/bb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bb_config.svh"

module bb_top
(
  input  wire                           clk_6M,
  input  wire                           rstz,
  input  wire                           reg_we,
  input  wire bb_pkg::reg_addr_e        reg_addr,
  input  wire logic [31:0]              reg_wdata,
  input  wire                           rxbit,
  output wire logic [`BB_CLKN_W-1:0]    clkn,
  output wire                           p_1us,
  output wire                           slot_p,
  output wire bb_pkg::syncword_t        syncword,
  output wire                           sw_ready,
  output wire                           sync_hit
);

  import bb_pkg::*;

  bb_cfg_t  cfg;
  bb_tick_t tick;
  logic     calc_p;

  bb_cfg_regs u_cfg_regs (
    .clk_6M    (clk_6M    ),
    .rstz      (rstz      ),
    .reg_we    (reg_we    ),
    .reg_addr  (reg_addr  ),
    .reg_wdata (reg_wdata ),
    .cfg       (cfg       ),
    .calc_p    (calc_p    )
  );

  bb_clkgen u_clkgen (
    .clk_6M    (clk_6M    ),
    .rstz      (rstz      ),
    .tick      (tick      ),
    .clkn      (clkn      )
  );

  bb_syncword_gen u_syncword_gen (
    .clk_6M    (clk_6M    ),
    .rstz      (rstz      ),
    .calc_p    (calc_p    ),
    .cfg       (cfg       ),
    .syncword  (syncword  ),
    .sw_ready  (sw_ready  )
  );

  bb_rx_correlator u_rx_correlator (
    .clk_6M    (clk_6M    ),
    .rstz      (rstz      ),
    .rxbit     (rxbit     ),
    .tick      (tick      ),
    .cfg       (cfg       ),
    .syncword  (syncword  ),
    .sw_ready  (sw_ready  ),
    .sync_hit  (sync_hit  )
  );

  assign p_1us  = tick.p_1us;
  assign slot_p = tick.slot_p;

endmodule

`default_nettype wire

// ==== verif/tb_bb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bb_config.svh"

module tb_bb_top;

  import bb_pkg::*;

  localparam logic [31:0] LFSR_SEED = 32'hc355_4c61;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam logic [63:0] PN        = `BB_PN;
  localparam int          HALF_SLOT = `BB_CYCLES_PER_HALF_SLOT;

  logic                  clk_6M;
  logic                  rstz;
  logic                  reg_we;
  reg_addr_e             reg_addr;
  logic [31:0]           reg_wdata;
  logic                  rxbit;
  logic [`BB_CLKN_W-1:0] clkn;
  logic                  p_1us;
  logic                  slot_p;
  syncword_t             syncword;
  logic                  sw_ready;
  logic                  sync_hit;

  logic [31:0]           lfsr;
  syncword_t             last_sw;
  int                    us_gap;
  int                    hs_gap;
  int                    slot_gap;
  int                    slot_cnt;
  logic                  us_seen;
  logic                  hs_seen;
  logic [`BB_CLKN_W-1:0] clkn_prev;

  bb_top u_dut (
    .clk_6M    (clk_6M    ),
    .rstz      (rstz      ),
    .reg_we    (reg_we    ),
    .reg_addr  (reg_addr  ),
    .reg_wdata (reg_wdata ),
    .rxbit     (rxbit     ),
    .clkn      (clkn      ),
    .p_1us     (p_1us     ),
    .slot_p    (slot_p    ),
    .syncword  (syncword  ),
    .sw_ready  (sw_ready  ),
    .sync_hit  (sync_hit  )
  );

  initial
  begin
    clk_6M = 1'b0;
    forever #2 clk_6M = ~clk_6M;
  end

  task automatic value_fail(input string msg);
    $display("ERR at %0t ns: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout while waiting for %s at %0t ns", what, $time);
    $display("Done: errors found");
    $fatal(1, "stopped on timeout");
  endtask

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return val;
  endfunction

  // long division of info * x^34 by the BCH generator
  function automatic logic [63:0] ref_syncword(input logic [23:0] lap);
    logic [29:0] info;
    logic [63:0] div;
    logic [63:0] poly;
    poly = 64'(`BB_BCH_POLY);
    info = {(lap[23] ? `BB_BARKER_1 : `BB_BARKER_0), lap} ^ PN[63:34];
    div  = {info, 34'b0};
    for (int i = 63; i >= 34; i--)
    begin
      if (div[i])
        div = div ^ (poly << (i - 34));
    end
    return {info, div[33:0]} ^ PN;
  endfunction

  function automatic logic [63:0] flip_bits(input logic [63:0] word, input int n);
    logic [63:0] mask;
    int          pos;
    mask = '0;
    while ($countones(mask) < n)
    begin
      pos       = int'(rand_bits(6));
      mask[pos] = 1'b1;
    end
    return word ^ mask;
  endfunction

  task automatic next_cycle();
    @(posedge clk_6M);
    #1;
  endtask

  task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    next_cycle();
    reg_we    = 1'b0;
  endtask

  task automatic wait_tick();
    int cnt;
    cnt = 0;
    do
    begin
      next_cycle();
      cnt++;
    end
    while (!p_1us && cnt < 4 * `BB_CYCLES_PER_US);
    if (!p_1us)
      timeout_fail("p_1us");
  endtask

  task automatic check_idle(input string when);
    assert (!sync_hit && !sw_ready && !p_1us && clkn == '0 && syncword == '0)
      else value_fail($sformatf("outputs not idle %s", when));
  endtask

  task automatic run_calc(input logic [23:0] lap);
    syncword_t exp_sw;
    int        cnt;
    exp_sw = ref_syncword(lap);
    assert (syncword == last_sw)
      else value_fail($sformatf("syncword changed to %016h before calc", syncword));
    reg_write(REG_LAP, 32'(lap));
    reg_write(REG_CALC, 32'hffff_ffff);
    // the reg_we edge counts as the first cycle
    cnt = 1;
    while (!sw_ready && cnt < 100)
    begin
      next_cycle();
      cnt++;
    end
    if (!sw_ready)
      timeout_fail("sw_ready after a REG_CALC write");
    assert (cnt == 32)
      else value_fail($sformatf("sw_ready after %0d cycles, expected 32", cnt));
    assert (syncword == exp_sw)
      else value_fail($sformatf("lap %06h syncword %016h expected %016h",
                                lap, syncword, exp_sw));
    last_sw = exp_sw;
  endtask

  // lsb first, one bit right after each p_1us
  task automatic send_word(input logic [63:0] word);
    for (int i = 0; i < 64; i++)
    begin
      wait_tick();
      rxbit = word[i];
    end
  endtask

  task automatic expect_hit(input string what);
    wait_tick();
    next_cycle();
    assert (sync_hit)
      else value_fail($sformatf("no sync_hit for %s", what));
  endtask

  task automatic expect_no_hit(input string what);
    for (int t = 0; t < 65; t++)
    begin
      wait_tick();
      rxbit = 1'b0;
      next_cycle();
      assert (!sync_hit)
        else value_fail($sformatf("unexpected sync_hit for %s", what));
    end
  endtask

  assert property (@(posedge clk_6M) disable iff (!rstz)
    slot_p |-> (!clkn[0] && $past(clkn[0])))
    else value_fail("slot_p without an odd to even clkn step");

  assert property (@(posedge clk_6M) disable iff (!rstz)
    ((clkn != $past(clkn)) && !clkn[0]) |-> slot_p)
    else value_fail("clkn odd to even step without slot_p");

  assert property (@(posedge clk_6M) disable iff (!rstz)
    sync_hit |-> $past(p_1us))
    else value_fail("sync_hit not one cycle after p_1us");

  assert property (@(posedge clk_6M) disable iff (!rstz)
    sw_ready |-> !$past(sw_ready))
    else value_fail("sw_ready longer than one cycle");

  // pulse spacing of p_1us, clkn and slot_p
  always @(posedge clk_6M)
  begin
    if (!rstz)
    begin
      us_gap    <= 0;
      hs_gap    <= 0;
      slot_gap  <= 0;
      slot_cnt  <= 0;
      us_seen   <= 1'b0;
      hs_seen   <= 1'b0;
      clkn_prev <= '0;
    end
    else
    begin
      clkn_prev <= clkn;
      us_gap    <= p_1us ? 0 : us_gap + 1;
      hs_gap    <= (clkn != clkn_prev) ? 0 : hs_gap + 1;
      slot_gap  <= slot_p ? 0 : slot_gap + 1;
      if (p_1us)
      begin
        assert (!us_seen || us_gap == `BB_CYCLES_PER_US - 1)
          else value_fail($sformatf("p_1us spacing %0d cycles", us_gap + 1));
        us_seen <= 1'b1;
      end
      if (clkn != clkn_prev)
      begin
        assert (clkn == clkn_prev + 1'b1)
          else value_fail($sformatf("clkn jumped from %0d to %0d", clkn_prev, clkn));
        assert (!hs_seen || hs_gap == HALF_SLOT - 1)
          else value_fail($sformatf("clkn step after %0d cycles", hs_gap + 1));
        hs_seen <= 1'b1;
      end
      if (slot_p)
      begin
        assert (slot_cnt == 0 || slot_gap == 2 * HALF_SLOT - 1)
          else value_fail($sformatf("slot_p spacing %0d cycles", slot_gap + 1));
        slot_cnt <= slot_cnt + 1;
      end
    end
  end

  initial
  begin
    logic [23:0] lap;
    syncword_t   word;
    int          cnt;
    rstz      = 1'b0;
    reg_we    = 1'b0;
    reg_addr  = REG_CTRL;
    reg_wdata = '0;
    rxbit     = 1'b0;
    lfsr      = LFSR_SEED;
    last_sw   = '0;
    repeat (5) next_cycle();
    check_idle("during reset");
    rstz = 1'b1;
    next_cycle();
    check_idle("right after reset");

    // all zero input matches the reset word, but no sync word is valid yet
    reg_write(REG_CTRL, 32'd1);
    expect_no_hit("no valid sync word");
    reg_write(REG_CTRL, 32'd0);

    // both barker appends, then random laps
    run_calc(24'h000000);
    run_calc(24'hffffff);
    for (int i = 0; i < 8; i++)
    begin
      lap = 24'(rand_bits(24));
      run_calc(lap);
    end

    lap  = 24'(rand_bits(24));
    run_calc(lap);
    word = ref_syncword(lap);
    reg_write(REG_CTRL, 32'd1);
    reg_write(REG_THRESH, 32'd0);
    send_word(word);
    expect_hit("exact word with thresh 0");
    reg_write(REG_THRESH, 32'd3);
    send_word(flip_bits(word, 3));
    expect_hit("3 flipped bits with thresh 3");
    send_word(flip_bits(word, 4));
    expect_no_hit("4 flipped bits with thresh 3");
    reg_write(REG_CTRL, 32'd0);
    reg_write(REG_THRESH, 32'd0);
    send_word(word);
    expect_no_hit("disabled correlator");

    // let a few slots pass for the spacing checks
    cnt = 0;
    while (slot_cnt < 3 && cnt < 8 * HALF_SLOT)
    begin
      next_cycle();
      cnt++;
    end
    if (slot_cnt < 3)
      timeout_fail("three slot pulses");
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
source/bb_pkg.sv
source/bb_cfg_regs.sv
source/bb_clkgen.sv
source/bb_syncword_gen.sv
source/bb_rx_correlator.sv
source/bb_top.sv
verif/tb_bb_top.sv

// ==== Makefile ====
# Verilator flow for the baseband subset

TOP        ?= tb_bb_top
RTL_TOP    ?= bb_top
VERILATOR  ?= verilator
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
FLAGS      ?= --timing -Wno-fatal
LINT_FLAGS ?= -Wall -Wno-fatal
PASS_TEXT  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
